/* logic/spm_pkg.sv */
// Word width, memory depth, opcode and state enums, bus selects, control and host structs

package spm_pkg;

  localparam int WORD_W    = 8;   // Data, address and instruction width
  localparam int MEM_DEPTH = 256; // Unified program and data memory

  typedef logic [WORD_W-1:0] word_t;

  // Instruction format is opcode[7:4], source[3:2], destination[1:0]
  typedef enum logic [3:0] {
    op_nop = 4'd0,
    op_add = 4'd1,
    op_sub = 4'd2,
    op_and = 4'd3,
    op_not = 4'd4,
    op_rd  = 4'd5,
    op_wr  = 4'd6,
    op_br  = 4'd7,
    op_brz = 4'd8  // Anything above halts
  } opcode_e;

  typedef enum logic [3:0] {
    st_idle = 4'd0,
    st_fet1 = 4'd1,
    st_fet2 = 4'd2,
    st_dec  = 4'd3,
    st_ex1  = 4'd4,
    st_rd1  = 4'd5,
    st_rd2  = 4'd6,
    st_wr1  = 4'd7,
    st_wr2  = 4'd8,
    st_br1  = 4'd9,
    st_br2  = 4'd10,
    st_halt = 4'd11
  } state_e;

  typedef enum logic [2:0] {
    sel1_r0 = 3'd0,
    sel1_r1 = 3'd1,
    sel1_r2 = 3'd2,
    sel1_r3 = 3'd3,
    sel1_pc = 3'd4
  } bus1_sel_e;

  typedef enum logic [1:0] {
    sel2_alu  = 2'd0,
    sel2_bus1 = 2'd1,
    sel2_mem  = 2'd2
  } bus2_sel_e;

  // One strobe per register plus the two bus selects
  typedef struct packed {
    logic [3:0] reg_load;  // R3..R0 load mask
    logic       pc_load;
    logic       pc_inc;
    logic       ir_load;
    logic       addr_load;
    logic       y_load;
    logic       z_load;
    logic       mem_write;
    bus1_sel_e  bus1_sel;
    bus2_sel_e  bus2_sel;
  } ctrl_t;

  typedef struct packed {
    logic  en;
    word_t addr;
    word_t data;
  } host_req_t;

endpackage

/* logic/spm_memory.sv */
// Unified 256-byte memory with a processor port and a host load and readback port

`timescale 1ns/1ps

module spm_memory (
  input  logic               clk,
  input  spm_pkg::ctrl_t     ctrl_i,
  input  spm_pkg::word_t     address_i,
  input  spm_pkg::word_t     wdata_i,
  output spm_pkg::word_t     rdata_o,
  input  spm_pkg::host_req_t host_req_i,
  input  spm_pkg::word_t     host_addr_i,
  output spm_pkg::word_t     host_data_o
);

  spm_pkg::word_t mem [spm_pkg::MEM_DEPTH];

  // Both read ports are asynchronous
  assign rdata_o     = mem[address_i];
  assign host_data_o = mem[host_addr_i];

  // Host writes only while the processor is stopped
  always_ff @(posedge clk) begin
    if (host_req_i.en) begin
      mem[host_req_i.addr] <= host_req_i.data;
    end
    if (ctrl_i.mem_write) begin
      mem[address_i] <= wdata_i;  // Processor store wins on a collision
    end
  end

endmodule

/* logic/spm_register_bus.sv */
// General registers R0 to R3 with the bus 1 and bus 2 multiplexers

`timescale 1ns/1ps

module spm_register_bus (
  input  logic           clk,
  input  logic           rst,
  input  spm_pkg::ctrl_t ctrl_i,
  input  spm_pkg::word_t pc_i,
  input  spm_pkg::word_t alu_i,
  input  spm_pkg::word_t mem_i,
  output spm_pkg::word_t bus1_o,
  output spm_pkg::word_t bus2_o
);

  spm_pkg::word_t regs [4];

  // All four registers load from bus 2
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 4; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (ctrl_i.reg_load[i]) begin
          regs[i] <= bus2_o;
        end
      end
    end
  end

  // Bus 1 source
  always_comb begin
    case (ctrl_i.bus1_sel)
      spm_pkg::sel1_r0: bus1_o = regs[0];
      spm_pkg::sel1_r1: bus1_o = regs[1];
      spm_pkg::sel1_r2: bus1_o = regs[2];
      spm_pkg::sel1_r3: bus1_o = regs[3];
      spm_pkg::sel1_pc: bus1_o = pc_i;
      default:          bus1_o = '0;
    endcase
  end

  // Bus 2 source
  always_comb begin
    case (ctrl_i.bus2_sel)
      spm_pkg::sel2_alu:  bus2_o = alu_i;
      spm_pkg::sel2_bus1: bus2_o = bus1_o;
      spm_pkg::sel2_mem:  bus2_o = mem_i;
      default:            bus2_o = '0;
    endcase
  end

endmodule

/* logic/spm_alu.sv */
// ALU with operand register Y and zero flag register Z

`timescale 1ns/1ps

module spm_alu (
  input  logic             clk,
  input  logic             rst,
  input  spm_pkg::ctrl_t   ctrl_i,
  input  spm_pkg::opcode_e opcode_i,
  input  spm_pkg::word_t   bus1_i,
  input  spm_pkg::word_t   bus2_i,
  output spm_pkg::word_t   alu_o,
  output logic             zero_o
);

  spm_pkg::word_t y_q;  // Holds the source operand

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      y_q    <= '0;
      zero_o <= 1'b0;
    end else begin
      if (ctrl_i.y_load) y_q <= bus2_i;
      if (ctrl_i.z_load) zero_o <= (alu_o == '0);
    end
  end

  // Bus 1 carries the destination, or the source for NOT
  always_comb begin
    case (opcode_i)
      spm_pkg::op_add: alu_o = y_q + bus1_i;
      spm_pkg::op_sub: alu_o = bus1_i - y_q;  // Dest minus src
      spm_pkg::op_and: alu_o = y_q & bus1_i;
      spm_pkg::op_not: alu_o = ~bus1_i;
      default:         alu_o = '0;
    endcase
  end

endmodule

/* logic/spm_fetch.sv */
// Program counter, instruction register and address register

`timescale 1ns/1ps

module spm_fetch (
  input  logic           clk,
  input  logic           rst,
  input  spm_pkg::ctrl_t ctrl_i,
  input  spm_pkg::word_t bus2_i,
  output spm_pkg::word_t pc_o,
  output spm_pkg::word_t instruction_o,
  output spm_pkg::word_t address_o
);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc_o <= '0;
    end else if (ctrl_i.pc_load) begin
      pc_o <= bus2_i;  // Branch target
    end else if (ctrl_i.pc_inc) begin
      pc_o <= pc_o + 1'b1;  // Wraps at 256
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      instruction_o <= '0;
    end else if (ctrl_i.ir_load) begin
      instruction_o <= bus2_i;
    end
  end

  // Drives the processor port of the memory
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      address_o <= '0;
    end else if (ctrl_i.addr_load) begin
      address_o <= bus2_i;
    end
  end

endmodule

/* logic/spm_control.sv */
// Multi-cycle controller that decodes instructions and drives the control struct

`timescale 1ns/1ps

module spm_control (
  input  logic           clk,
  input  logic           rst,
  input  logic           run_i,
  input  spm_pkg::word_t instruction_i,
  input  logic           zero_i,
  output spm_pkg::ctrl_t ctrl_o,
  output logic           halted_o
);

  spm_pkg::state_e  state;
  spm_pkg::state_e  next_state;
  spm_pkg::opcode_e opcode;
  logic [1:0]       src;
  logic [1:0]       dest;

  assign opcode = spm_pkg::opcode_e'(instruction_i[7:4]);
  assign src    = instruction_i[3:2];
  assign dest   = instruction_i[1:0];

  assign halted_o = (state == spm_pkg::st_halt);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state <= spm_pkg::st_idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    ctrl_o     = '0;
    next_state = state;

    case (state)
      spm_pkg::st_idle: begin
        if (run_i) next_state = spm_pkg::st_fet1;
      end

      spm_pkg::st_fet1: begin  // Address register gets PC
        ctrl_o.bus1_sel  = spm_pkg::sel1_pc;
        ctrl_o.bus2_sel  = spm_pkg::sel2_bus1;
        ctrl_o.addr_load = 1'b1;
        next_state       = spm_pkg::st_fet2;
      end

      spm_pkg::st_fet2: begin
        ctrl_o.bus2_sel = spm_pkg::sel2_mem;
        ctrl_o.ir_load  = 1'b1;
        ctrl_o.pc_inc   = 1'b1;
        next_state      = spm_pkg::st_dec;
      end

      spm_pkg::st_dec: begin
        case (opcode)
          spm_pkg::op_nop: next_state = spm_pkg::st_fet1;

          spm_pkg::op_add, spm_pkg::op_sub, spm_pkg::op_and: begin
            ctrl_o.bus1_sel = spm_pkg::bus1_sel_e'({1'b0, src});
            ctrl_o.bus2_sel = spm_pkg::sel2_bus1;
            ctrl_o.y_load   = 1'b1;  // Source into Y
            next_state      = spm_pkg::st_ex1;
          end

          // Single pass through the ALU, so done in decode
          spm_pkg::op_not: begin
            ctrl_o.bus1_sel = spm_pkg::bus1_sel_e'({1'b0, src});
            ctrl_o.bus2_sel = spm_pkg::sel2_alu;
            ctrl_o.reg_load = 4'b0001 << dest;
            ctrl_o.z_load   = 1'b1;
            next_state      = spm_pkg::st_fet1;
          end

          spm_pkg::op_rd, spm_pkg::op_wr, spm_pkg::op_br: begin
            ctrl_o.bus1_sel  = spm_pkg::sel1_pc;  // Point at the second byte
            ctrl_o.bus2_sel  = spm_pkg::sel2_bus1;
            ctrl_o.addr_load = 1'b1;
            if (opcode == spm_pkg::op_rd) begin
              next_state = spm_pkg::st_rd1;
            end else if (opcode == spm_pkg::op_wr) begin
              next_state = spm_pkg::st_wr1;
            end else begin
              next_state = spm_pkg::st_br1;
            end
          end

          spm_pkg::op_brz: begin
            if (zero_i) begin
              ctrl_o.bus1_sel  = spm_pkg::sel1_pc;
              ctrl_o.bus2_sel  = spm_pkg::sel2_bus1;
              ctrl_o.addr_load = 1'b1;
              next_state       = spm_pkg::st_br1;
            end else begin
              ctrl_o.pc_inc = 1'b1;  // Skip the target byte
              next_state    = spm_pkg::st_fet1;
            end
          end

          default: next_state = spm_pkg::st_halt;
        endcase
      end

      spm_pkg::st_ex1: begin  // Dest on bus 1, result back into dest
        ctrl_o.bus1_sel = spm_pkg::bus1_sel_e'({1'b0, dest});
        ctrl_o.bus2_sel = spm_pkg::sel2_alu;
        ctrl_o.reg_load = 4'b0001 << dest;
        ctrl_o.z_load   = 1'b1;
        next_state      = spm_pkg::st_fet1;
      end

      spm_pkg::st_rd1, spm_pkg::st_wr1: begin
        ctrl_o.bus2_sel  = spm_pkg::sel2_mem;  // Operand address from second byte
        ctrl_o.addr_load = 1'b1;
        ctrl_o.pc_inc    = 1'b1;
        next_state = (state == spm_pkg::st_rd1) ? spm_pkg::st_rd2 : spm_pkg::st_wr2;
      end

      spm_pkg::st_rd2: begin
        ctrl_o.bus2_sel = spm_pkg::sel2_mem;
        ctrl_o.reg_load = 4'b0001 << dest;
        next_state      = spm_pkg::st_fet1;
      end

      spm_pkg::st_wr2: begin
        ctrl_o.bus1_sel  = spm_pkg::bus1_sel_e'({1'b0, src});
        ctrl_o.mem_write = 1'b1;
        next_state       = spm_pkg::st_fet1;
      end

      spm_pkg::st_br1: begin
        ctrl_o.bus2_sel  = spm_pkg::sel2_mem;
        ctrl_o.addr_load = 1'b1;
        next_state       = spm_pkg::st_br2;
      end

      spm_pkg::st_br2: begin  // Indirect target into PC
        ctrl_o.bus2_sel = spm_pkg::sel2_mem;
        ctrl_o.pc_load  = 1'b1;
        next_state      = spm_pkg::st_fet1;
      end

      spm_pkg::st_halt: next_state = spm_pkg::st_halt;  // Left only by reset

      default: next_state = spm_pkg::st_idle;
    endcase
  end

endmodule

/* logic/spm_top.sv */
// Processor top level joining controller, register file and buses, ALU, fetch and memory

`timescale 1ns/1ps

module spm_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               run_i,
  input  spm_pkg::host_req_t host_req_i,
  input  spm_pkg::word_t     mem_rd_addr_i,
  output spm_pkg::word_t     mem_rd_data_o,
  output logic               halted_o,
  output spm_pkg::word_t     data_bus_o,
  output spm_pkg::word_t     address_bus_o,
  output spm_pkg::word_t     instruction_bus_o
);

  spm_pkg::ctrl_t ctrl;
  spm_pkg::word_t instruction;
  spm_pkg::word_t address;
  spm_pkg::word_t pc;
  spm_pkg::word_t bus1;
  spm_pkg::word_t bus2;
  spm_pkg::word_t alu_out;
  spm_pkg::word_t mem_word;
  logic           zero;

  // Observation buses
  assign data_bus_o        = bus1;
  assign address_bus_o     = address;
  assign instruction_bus_o = instruction;

  spm_control u_control (
    .clk           (clk),
    .rst           (rst),
    .run_i         (run_i),
    .instruction_i (instruction),
    .zero_i        (zero),
    .ctrl_o        (ctrl),
    .halted_o      (halted_o)
  );

  spm_register_bus u_register_bus (
    .clk    (clk),
    .rst    (rst),
    .ctrl_i (ctrl),
    .pc_i   (pc),
    .alu_i  (alu_out),
    .mem_i  (mem_word),
    .bus1_o (bus1),
    .bus2_o (bus2)
  );

  spm_alu u_alu (
    .clk      (clk),
    .rst      (rst),
    .ctrl_i   (ctrl),
    .opcode_i (spm_pkg::opcode_e'(instruction[7:4])),  // Upper nibble of IR
    .bus1_i   (bus1),
    .bus2_i   (bus2),
    .alu_o    (alu_out),
    .zero_o   (zero)
  );

  spm_fetch u_fetch (
    .clk           (clk),
    .rst           (rst),
    .ctrl_i        (ctrl),
    .bus2_i        (bus2),
    .pc_o          (pc),
    .instruction_o (instruction),
    .address_o     (address)
  );

  spm_memory u_memory (
    .clk         (clk),
    .ctrl_i      (ctrl),
    .address_i   (address),
    .wdata_i     (bus1),
    .rdata_o     (mem_word),
    .host_req_i  (host_req_i),
    .host_addr_i (mem_rd_addr_i),
    .host_data_o (mem_rd_data_o)
  );

endmodule

/* bench/spm_tb_model.svh */
// Image type and instruction-level reference model of the processor
`ifndef SPM_TB_MODEL_SVH
`define SPM_TB_MODEL_SVH

typedef logic [255:0][7:0] image_t;  // Byte n at index n

localparam int MODEL_STEP_LIMIT = 4096;

// Runs from PC 0 with cleared registers and Z until a halt opcode
function automatic image_t run_model(input image_t start);
  image_t          img;
  logic [3:0][7:0] regs;
  logic [7:0]      pc;
  logic [7:0]      ins;
  logic [7:0]      ptr;  // Second byte, holds the operand address
  logic [7:0]      res;
  logic            z;
  logic            stop;
  img  = start;
  regs = '0;
  pc   = 8'd0;
  z    = 1'b0;
  stop = 1'b0;
  for (int step = 0; step < MODEL_STEP_LIMIT && !stop; step++) begin
    ins = img[pc];
    ptr = img[pc + 8'd1];
    res = 8'd0;
    case (ins[7:4])
      spm_pkg::op_nop: pc = pc + 8'd1;
      spm_pkg::op_add: res = regs[ins[1:0]] + regs[ins[3:2]];
      spm_pkg::op_sub: res = regs[ins[1:0]] - regs[ins[3:2]];
      spm_pkg::op_and: res = regs[ins[1:0]] & regs[ins[3:2]];
      spm_pkg::op_not: res = ~regs[ins[3:2]];
      spm_pkg::op_rd: begin
        regs[ins[1:0]] = img[ptr];
        pc = pc + 8'd2;
      end
      spm_pkg::op_wr: begin
        img[ptr] = regs[ins[3:2]];
        pc = pc + 8'd2;
      end
      spm_pkg::op_br:  pc = img[ptr];  // Indirect
      spm_pkg::op_brz: pc = z ? img[ptr] : pc + 8'd2;
      default:         stop = 1'b1;
    endcase
    if (ins[7:4] >= 4'd1 && ins[7:4] <= 4'd4) begin  // ALU group writes dest and Z
      regs[ins[1:0]] = res;
      z  = (res == 8'd0);
      pc = pc + 8'd1;
    end
  end
  return img;
endfunction

`endif

/* bench/spm_tb.sv */
// Testbench for the processor with host port, directed and random programs

`timescale 1ns/1ps

module spm_tb;

  `include "spm_tb_model.svh"

  localparam int HALT_TIMEOUT = 2000;  // Cycles per program

  logic               clk;
  logic               rst;
  logic               run;
  spm_pkg::host_req_t host_req;
  spm_pkg::word_t     rd_addr;
  spm_pkg::word_t     rd_data;
  logic               halted;
  spm_pkg::word_t     data_bus;
  spm_pkg::word_t     address_bus;
  spm_pkg::word_t     instruction_bus;
  integer             seed;
  image_t             prog;
  spm_pkg::word_t     wp;  // Assembly pointer

  spm_top dut (
    .clk               (clk),
    .rst               (rst),
    .run_i             (run),
    .host_req_i        (host_req),
    .mem_rd_addr_i     (rd_addr),
    .mem_rd_data_o     (rd_data),
    .halted_o          (halted),
    .data_bus_o        (data_bus),
    .address_bus_o     (address_bus),
    .instruction_bus_o (instruction_bus)
  );

  always #10 clk = ~clk;

  task automatic check_equal(input spm_pkg::word_t actual, input spm_pkg::word_t expected,
                             input string msg);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s, got %02h expected %02h", $time, msg, actual, expected);
      $display("*** FAILED ***");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b0;
    run = 1'b0;
    repeat (3) @(negedge clk);
    rst = 1'b1;
  endtask

  task automatic host_write(input spm_pkg::word_t addr, input spm_pkg::word_t data);
    @(negedge clk);
    host_req = {1'b1, addr, data};
    @(negedge clk);
    host_req.en = 1'b0;
  endtask

  task automatic check_byte(input spm_pkg::word_t addr, input spm_pkg::word_t expected,
                            input string msg);
    @(negedge clk);
    rd_addr = addr;
    @(posedge clk);  // Read port settled since the falling edge
    check_equal(rd_data, expected, $sformatf("%s, byte %02h", msg, addr));
  endtask

  task automatic wait_halt(input string msg);
    int cycles;
    cycles = 0;
    while (!halted && cycles < HALT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("%s: processor did not halt within %0d cycles", msg, HALT_TIMEOUT);
      $display("*** FAILED ***");
      $fatal(1, "halt timeout");
    end
  endtask

  task automatic start_program(input bit random_fill);
    for (int a = 0; a < 256; a++) begin
      prog[a] = random_fill ? spm_pkg::word_t'($random(seed)) : spm_pkg::word_t'(a) ^ 8'h96;
    end
    wp = 8'd0;
  endtask

  task automatic emit(input spm_pkg::word_t b);
    prog[wp] = b;
    wp = wp + 8'd1;
  endtask

  // RD names a destination and WR a source, so the register goes in both fields
  task automatic emit_mem(input spm_pkg::opcode_e op, input logic [1:0] r,
                          input spm_pkg::word_t ptr);
    emit({op, r, r});
    emit(ptr);
  endtask

  task automatic run_and_compare(input string msg);
    image_t expected;
    expected = run_model(prog);
    apply_reset();
    for (int a = 0; a < 256; a++) begin
      host_write(spm_pkg::word_t'(a), prog[a]);
    end
    @(negedge clk);
    run = 1'b1;
    wait_halt(msg);
    for (int a = 0; a < 256; a++) begin
      check_byte(spm_pkg::word_t'(a), expected[a], msg);
    end
  endtask

  initial begin
    spm_pkg::word_t addr;
    spm_pkg::word_t rnd;
    logic [3:0]     halt_op;
    image_t         shadow;
    spm_pkg::word_t written [$];
    seed     = 32'h12791a09;
    clk      = 1'b0;
    rst      = 1'b0;
    run      = 1'b0;
    host_req = '0;
    rd_addr  = '0;
    apply_reset();
    repeat (4) @(negedge clk);  // Idle holds while run is low
    check_equal(halted, 1'b0, "halted after reset");
    check_equal(instruction_bus, 8'h00, "instruction register after reset");
    check_equal(address_bus, 8'h00, "address register after reset");
    check_equal(data_bus, 8'h00, "bus 1 after reset");
    for (int i = 0; i < 32; i++) begin
      addr         = $random(seed);
      shadow[addr] = $random(seed);
      host_write(addr, shadow[addr]);
      written.push_back(addr);
    end
    foreach (written[i]) begin
      check_byte(written[i], shadow[written[i]], "host readback");
    end
    // Chained ALU results from R0 = 5A and R1 = 3C
    start_program(1'b0);
    prog[8'hC0] = 8'h5A;
    prog[8'hC1] = 8'h3C;
    emit_mem(spm_pkg::op_rd, 2'd0, 8'hC0);
    emit_mem(spm_pkg::op_rd, 2'd1, 8'hC1);
    emit({spm_pkg::op_add, 2'd1, 2'd0});
    emit_mem(spm_pkg::op_wr, 2'd0, 8'hD0);
    emit({spm_pkg::op_sub, 2'd1, 2'd0});
    emit_mem(spm_pkg::op_wr, 2'd0, 8'hD1);
    emit({spm_pkg::op_and, 2'd1, 2'd0});
    emit_mem(spm_pkg::op_wr, 2'd0, 8'hD2);
    emit({spm_pkg::op_not, 2'd0, 2'd3});
    emit_mem(spm_pkg::op_wr, 2'd3, 8'hD3);
    emit({spm_pkg::op_nop, 4'd0});
    emit(8'hF0);
    run_and_compare("arithmetic");
    start_program(1'b0);
    prog[8'hC0] = 8'h5A;
    emit_mem(spm_pkg::op_rd, 2'd0, 8'hC0);
    emit_mem(spm_pkg::op_br, 2'd0, 8'hE0);
    emit_mem(spm_pkg::op_wr, 2'd0, 8'hD0);  // Jumped over
    prog[8'hE0] = wp;
    emit_mem(spm_pkg::op_rd, 2'd1, 8'hC0);
    emit({spm_pkg::op_sub, 2'd0, 2'd1});  // Equal registers give Z
    emit_mem(spm_pkg::op_brz, 2'd0, 8'hE1);
    emit_mem(spm_pkg::op_wr, 2'd0, 8'hD1);
    prog[8'hE1] = wp;
    emit_mem(spm_pkg::op_wr, 2'd0, 8'hD2);
    emit({spm_pkg::op_not, 2'd0, 2'd2});
    emit_mem(spm_pkg::op_brz, 2'd0, 8'hE2);  // Falls through
    emit_mem(spm_pkg::op_wr, 2'd2, 8'hD3);
    prog[8'hE2] = wp;
    emit(8'hF0);
    run_and_compare("branches");
    for (int p = 0; p < 6; p++) begin
      start_program(1'b1);
      for (int i = 0; i < 12; i++) begin
        rnd = $random(seed);
        case (rnd[7:6])
          2'd0:    emit_mem(spm_pkg::op_rd, rnd[1:0], 8'hC0 + rnd[5:2]);
          2'd1:    emit_mem(spm_pkg::op_wr, rnd[1:0], 8'hD0 + rnd[5:2]);
          default: emit({4'd1 + {2'b00, rnd[5:4]}, rnd[3:2], rnd[1:0]});
        endcase
      end
      rnd     = $random(seed);
      halt_op = 4'd9 + (rnd[2:0] % 3'd7);  // Any opcode from 9 to 15
      emit({halt_op, rnd[7:4]});
      run_and_compare($sformatf("random program %0d", p));
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* all.f */
+incdir+bench
logic/spm_pkg.sv
logic/spm_memory.sv
logic/spm_register_bus.sv
logic/spm_alu.sv
logic/spm_fetch.sv
logic/spm_control.sv
logic/spm_top.sv
bench/spm_tb.sv
